//--- all.f
+incdir+bench
design/cache_geom_pkg.sv
design/cmo_pkg.sv
design/cmo_walker.sv
design/cmo_flush_queue.sv
design/cmo_sequencer.sv
design/cmo_handler.sv
bench/tb_clock.sv
bench/tb_cmo_handler.sv

//--- run.sh
#!/bin/sh
# Compile and run the cmo_handler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_cmo_handler -o tb_cmo_handler

output=$(./obj_dir/tb_cmo_handler)
echo "$output"

# The run passes only if the testbench printed its pass line
if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

//--- bench/tb_cmo_tests.svh
/* Directed tests for cmo_handler, included inside the testbench module.
   Inputs change on rising edges; outputs are read right after an edge, before any update. */
`ifndef TB_CMO_TESTS_SVH
`define TB_CMO_TESTS_SVH

task automatic send_req(input cmo_op_e op, input addr_t addr);
    int n;
    n = 0;
    @(posedge clk);
    req_valid <= 1'b1;
    req_op    <= op;
    req_addr  <= addr;
    @(posedge clk);
    while (!req_ready && n < WAIT_LIMIT) begin
        @(posedge clk);
        n++;
    end
    if (!req_ready) begin
        report_failure("request was never accepted");
    end
    req_valid <= 1'b0;
endtask

task automatic wait_ready(input int limit, input string what);
    int n;
    n = 0;
    @(posedge clk);
    while (!req_ready && n < limit) begin
        @(posedge clk);
        n++;
    end
    if (!req_ready) begin
        report_failure({"ready did not return after ", what});
    end
endtask

// Each call writes one directory entry on the following edge
task automatic load_entry(input int s, input int w, input logic v, input logic d,
                          input tag_t t);
    @(posedge clk);
    load_en    <= 1'b1;
    load_set   <= set_t'(s);
    load_way   <= w;
    load_valid <= v;
    load_dirty <= d;
    load_tag   <= t;
endtask

task automatic finish_load();
    @(posedge clk);
    load_en <= 1'b0;
endtask

task automatic check_after_reset();
    int n;
    n = 0;
    // Reset may still be unknown at time zero
    while (rst_n !== 1'b1 && n < WAIT_LIMIT) begin
        @(posedge clk);
        n++;
    end
    if (rst_n !== 1'b1) begin
        report_failure("reset was never released");
    end
    @(posedge clk);
    if (req_ready !== 1'b1) begin
        report_mismatch("req_ready_o", req_ready, 1);
    end
    if (req_wait !== 1'b0) begin
        report_mismatch("req_wait_o", req_wait, 0);
    end
    if ({dir_check_nline, dir_check_entry, dir_inval} !== 3'b000) begin
        report_mismatch("directory strobes", {dir_check_nline, dir_check_entry, dir_inval}, 0);
    end
    if (wbuf_flush_all !== 1'b0) begin
        report_mismatch("wbuf_flush_all_o", wbuf_flush_all, 0);
    end
    if (flush_alloc !== 1'b0) begin
        report_mismatch("flush_alloc_o", flush_alloc, 0);
    end
endtask

task automatic fence_sequence();
    @(posedge clk);
    wbuf_empty <= 1'b0;
    send_req(CMO_FENCE, '0);
    repeat (4) begin
        @(posedge clk);
        if (req_wait !== 1'b1) begin
            report_mismatch("req_wait_o", req_wait, 1);
        end
        if (req_ready !== 1'b0) begin
            report_mismatch("req_ready_o", req_ready, 0);
        end
        if (wbuf_flush_all !== 1'b1) begin
            report_mismatch("wbuf_flush_all_o", wbuf_flush_all, 1);
        end
    end
    // Busy replay table holds back the write buffer drain
    rtab_empty <= 1'b0;
    @(posedge clk);
    if (wbuf_flush_all !== 1'b0) begin
        report_mismatch("wbuf_flush_all_o", wbuf_flush_all, 0);
    end
    rtab_empty <= 1'b1;
    wbuf_empty <= 1'b1;
    wait_ready(WAIT_LIMIT, "fence");
    // Nothing pending, so the handler never leaves IDLE
    send_req(CMO_FENCE, '0);
    @(posedge clk);
    if (req_ready !== 1'b1) begin
        report_mismatch("req_ready_o", req_ready, 1);
    end
    if (req_wait !== 1'b0) begin
        report_mismatch("req_wait_o", req_wait, 0);
    end
endtask

task automatic drain_before_inval_all();
    int base;
    int strobes;
    @(posedge clk);
    mshr_empty <= 1'b0;
    base    = inval_set_log.size();
    strobes = strobe_count;
    send_req(CMO_INVAL_ALL, '0);
    repeat (5) begin
        @(posedge clk);
        if (req_wait !== 1'b1) begin
            report_mismatch("req_wait_o", req_wait, 1);
        end
    end
    if (strobe_count != strobes) begin
        report_failure("directory strobe while the miss table was busy");
    end
    mshr_empty <= 1'b1;
    wait_ready(WAIT_LIMIT, "invalidate all");
    if (inval_set_log.size() - base != NUM_SETS) begin
        report_mismatch("invalidate count", inval_set_log.size() - base, NUM_SETS);
    end else begin
        for (int i = 0; i < NUM_SETS; i++) begin
            if (inval_set_log[base + i] !== set_t'(i)) begin
                report_mismatch("dir_inval_set_o", inval_set_log[base + i], i);
            end
            if (inval_way_log[base + i] !== '1) begin
                report_mismatch("dir_inval_way_o", inval_way_log[base + i], 4'hf);
            end
        end
    end
endtask

task automatic inval_one_line();
    int base;
    load_entry(5, 2, 1'b1, 1'b0, 8'h3c);
    load_entry(5, 0, 1'b1, 1'b1, 8'h11);
    finish_load();
    base = inval_set_log.size();
    send_req(CMO_INVAL_NLINE, {8'h3c, 4'd5, 4'h7});
    wait_ready(WAIT_LIMIT, "invalidate of a present line");
    if (dir_valid[5][2] !== 1'b0) begin
        report_mismatch("valid of set 5 way 2", dir_valid[5][2], 0);
    end
    if (dir_valid[5][0] !== 1'b1) begin
        report_mismatch("valid of set 5 way 0", dir_valid[5][0], 1);
    end
    if (inval_set_log.size() != base + 1) begin
        report_failure("a hit did not give exactly one invalidate");
    end else begin
        if (inval_set_log[base] !== set_t'(5)) begin
            report_mismatch("dir_inval_set_o", inval_set_log[base], 5);
        end
        if (inval_way_log[base] !== 4'b0100) begin
            report_mismatch("dir_inval_way_o", inval_way_log[base], 4'b0100);
        end
    end
    // Tag 0x99 is absent from set 5
    base = inval_set_log.size();
    send_req(CMO_INVAL_NLINE, {8'h99, 4'd5, 4'h0});
    wait_ready(WAIT_LIMIT, "invalidate of a missing line");
    if (inval_set_log.size() != base) begin
        report_failure("invalidate issued for a missing line");
    end
    if (dir_valid[5][0] !== 1'b1) begin
        report_mismatch("valid of set 5 way 0", dir_valid[5][0], 1);
    end
endtask

task automatic flush_under_backpressure();
    nline_t     exp_nline [$];
    way_vec_t   exp_way [$];
    logic [7:0] v;
    logic [7:0] d;
    logic [7:0] t;
    int         base;
    for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < WAYS; w++) begin
            take_random(1, v);
            take_random(1, d);
            take_random(8, t);
            load_entry(s, w, v[0], d[0], t);
            if (v[0] && d[0]) begin
                exp_nline.push_back({t, set_t'(s)});
                exp_way.push_back(way_vec_t'(1) << w);
            end
        end
    end
    finish_load();
    base = pop_nline_log.size();
    bp_en <= 1'b1;
    send_req(CMO_FLUSH_ALL, '0);
    wait_ready(FLUSH_LIMIT, "flush all");
    // All pops are logged before the cycle in which ready rises
    if (pop_nline_log.size() - base != exp_nline.size()) begin
        report_mismatch("flush pop count", pop_nline_log.size() - base, exp_nline.size());
    end else begin
        for (int i = 0; i < exp_nline.size(); i++) begin
            if (pop_nline_log[base + i] !== exp_nline[i]) begin
                report_mismatch("flush_alloc_nline_o", pop_nline_log[base + i], exp_nline[i]);
            end
            if (pop_way_log[base + i] !== exp_way[i]) begin
                report_mismatch("flush_alloc_way_o", pop_way_log[base + i], exp_way[i]);
            end
        end
    end
    if (flush_alloc !== 1'b0) begin
        report_mismatch("flush_alloc_o", flush_alloc, 0);
    end
    bp_en <= 1'b0;
endtask

`endif

//--- bench/tb_cmo_handler.sv
/* Testbench for cmo_handler with a directory model and a flush consumer under random
   back-pressure. Geometry follows cache_geom_pkg; flush_empty_i stays high throughout. */
`timescale 1ns/1ns

module tb_cmo_handler
    import cache_geom_pkg::*;
    import cmo_pkg::*;
();

    localparam int NUM_SETS    = 16;
    localparam int FLUSH_DEPTH = 3;
    localparam int WAIT_LIMIT  = 200;
    localparam int FLUSH_LIMIT = 4000;

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    logic     req_ready;
    cmo_op_e  req_op;
    addr_t    req_addr;
    logic     req_wait;
    logic     wbuf_empty;
    logic     mshr_empty;
    logic     rtab_empty;
    logic     wbuf_flush_all;
    logic     dir_check_nline;
    set_t     dir_check_nline_set;
    tag_t     dir_check_nline_tag;
    way_vec_t hit_way = '0;
    logic     dir_check_entry;
    set_t     dir_check_entry_set;
    way_vec_t dir_check_entry_way;
    logic     entry_valid = 1'b0;
    logic     entry_dirty = 1'b0;
    tag_t     entry_tag = '0;
    logic     dir_inval;
    set_t     dir_inval_set;
    way_vec_t dir_inval_way;
    logic     flush_empty;
    logic     flush_alloc;
    logic     flush_ready = 1'b1;
    nline_t   flush_nline;
    way_vec_t flush_way;

    // Directory model contents and its load port, driven by the tests
    logic     dir_valid [NUM_SETS][WAYS] = '{default: 1'b0};
    logic     dir_dirty [NUM_SETS][WAYS] = '{default: 1'b0};
    tag_t     dir_tag   [NUM_SETS][WAYS] = '{default: '0};
    logic     load_en;
    set_t     load_set;
    int       load_way;
    logic     load_valid;
    logic     load_dirty;
    tag_t     load_tag;

    // Observed traffic, appended by the monitor only
    set_t     inval_set_log [$];
    way_vec_t inval_way_log [$];
    nline_t   pop_nline_log [$];
    way_vec_t pop_way_log [$];
    int       strobe_count = 0;

    logic [31:0] ready_lfsr = 32'd67512;
    logic [31:0] fill_lfsr = 32'd67512;
    logic        bp_en = 1'b0;
    int          mismatch_count = 0;
    int          failure_count = 0;

    tb_clock clock_inst (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    cmo_handler #(
        .NUM_SETS    (NUM_SETS),
        .FLUSH_DEPTH (FLUSH_DEPTH)
    ) cmo_handler_inst (
        .clk_i                     (clk),
        .rst_ni                    (rst_n),
        .req_valid_i               (req_valid),
        .req_ready_o               (req_ready),
        .req_op_i                  (req_op),
        .req_addr_i                (req_addr),
        .req_wait_o                (req_wait),
        .wbuf_empty_i              (wbuf_empty),
        .mshr_empty_i              (mshr_empty),
        .rtab_empty_i              (rtab_empty),
        .wbuf_flush_all_o          (wbuf_flush_all),
        .dir_check_nline_o         (dir_check_nline),
        .dir_check_nline_set_o     (dir_check_nline_set),
        .dir_check_nline_tag_o     (dir_check_nline_tag),
        .dir_check_nline_hit_way_i (hit_way),
        .dir_check_entry_o         (dir_check_entry),
        .dir_check_entry_set_o     (dir_check_entry_set),
        .dir_check_entry_way_o     (dir_check_entry_way),
        .dir_check_entry_valid_i   (entry_valid),
        .dir_check_entry_dirty_i   (entry_dirty),
        .dir_check_entry_tag_i     (entry_tag),
        .dir_inval_o               (dir_inval),
        .dir_inval_set_o           (dir_inval_set),
        .dir_inval_way_o           (dir_inval_way),
        .flush_empty_i             (flush_empty),
        .flush_alloc_o             (flush_alloc),
        .flush_alloc_ready_i       (flush_ready),
        .flush_alloc_nline_o       (flush_nline),
        .flush_alloc_way_o         (flush_way)
    );

    // Fibonacci LFSR, taps 32 22 2 1, new bit enters at bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random(input int nbits, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            fill_lfsr = lfsr_step(fill_lfsr);
            value     = {value[6:0], fill_lfsr[0]};
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        mismatch_count++;
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t ns: %s", $time, what);
        failure_count++;
    endtask

    // Directory answers one cycle after a check, invalidates apply at the edge
    always @(posedge clk) begin
        hit_way <= '0;
        for (int w = 0; w < WAYS; w++) begin
            if (dir_check_nline) begin
                hit_way[w] <= dir_valid[dir_check_nline_set][w] &&
                              (dir_tag[dir_check_nline_set][w] == dir_check_nline_tag);
            end
            if (dir_check_entry && dir_check_entry_way[w]) begin
                entry_valid <= dir_valid[dir_check_entry_set][w];
                entry_dirty <= dir_dirty[dir_check_entry_set][w];
                entry_tag   <= dir_tag[dir_check_entry_set][w];
            end
            if (dir_inval && dir_inval_way[w]) begin
                dir_valid[dir_inval_set][w] <= 1'b0;
            end
        end
        if (load_en) begin
            dir_valid[load_set][load_way] <= load_valid;
            dir_dirty[load_set][load_way] <= load_dirty;
            dir_tag[load_set][load_way]   <= load_tag;
        end
    end

    // Flush consumer ready, random only while back-pressure is enabled
    always @(posedge clk) begin
        logic [31:0] next_state;
        next_state = lfsr_step(ready_lfsr);
        if (bp_en) begin
            ready_lfsr  <= next_state;
            flush_ready <= next_state[0];
        end else begin
            flush_ready <= 1'b1;
        end
    end

    // Monitor samples mid-cycle, where every DUT output is settled
    always @(negedge clk) begin
        if (dir_inval || dir_check_nline || dir_check_entry) begin
            strobe_count++;
        end
        if (dir_inval) begin
            inval_set_log.push_back(dir_inval_set);
            inval_way_log.push_back(dir_inval_way);
        end
        if (flush_alloc && flush_ready) begin
            pop_nline_log.push_back(flush_nline);
            pop_way_log.push_back(flush_way);
        end
    end

    `include "tb_cmo_tests.svh"

    initial begin
        req_valid   = 1'b0;
        req_op      = CMO_FENCE;
        req_addr    = '0;
        wbuf_empty  = 1'b1;
        mshr_empty  = 1'b1;
        rtab_empty  = 1'b1;
        flush_empty = 1'b1;
        load_en     = 1'b0;
        load_set    = '0;
        load_way    = 0;
        load_valid  = 1'b0;
        load_dirty  = 1'b0;
        load_tag    = '0;

        check_after_reset();
        fence_sequence();
        drain_before_inval_all();
        inval_one_line();
        flush_under_backpressure();

        $display("checks done: %0d mismatches, %0d other errors", mismatch_count,
                 failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- bench/tb_clock.sv
/* Free-running testbench clock; reset is held low for the first RESET_CYCLES rising edges */
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

//--- design/cmo_handler.sv
/* Cache maintenance handler for a write-back cache. NUM_SETS up to 16,
   FLUSH_DEPTH at least 2. */
`timescale 1ns/1ns

module cmo_handler
    import cache_geom_pkg::*;
    import cmo_pkg::*;
#(
    parameter int NUM_SETS    = 16,
    parameter int FLUSH_DEPTH = 3
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    input  cmo_op_e  req_op_i,
    input  addr_t    req_addr_i,
    output logic     req_wait_o,
    input  logic     wbuf_empty_i,
    input  logic     mshr_empty_i,
    input  logic     rtab_empty_i,
    output logic     wbuf_flush_all_o,
    output logic     dir_check_nline_o,
    output set_t     dir_check_nline_set_o,
    output tag_t     dir_check_nline_tag_o,
    input  way_vec_t dir_check_nline_hit_way_i,
    output logic     dir_check_entry_o,
    output set_t     dir_check_entry_set_o,
    output way_vec_t dir_check_entry_way_o,
    input  logic     dir_check_entry_valid_i,
    input  logic     dir_check_entry_dirty_i,
    input  tag_t     dir_check_entry_tag_i,
    output logic     dir_inval_o,
    output set_t     dir_inval_set_o,
    output way_vec_t dir_inval_way_o,
    input  logic     flush_empty_i,
    output logic     flush_alloc_o,
    input  logic     flush_alloc_ready_i,
    output nline_t   flush_alloc_nline_o,
    output way_vec_t flush_alloc_way_o
);

    logic     walk_start;
    logic     walk_step_way;
    logic     walk_step_set;
    set_t     walk_set;
    way_vec_t walk_way;
    logic     walk_set_last;
    logic     walk_way_last;
    logic     q_push;
    nline_t   q_nline;
    way_vec_t q_way;
    logic     q_space;
    logic     q_almost_full;
    logic     q_empty;

    cmo_sequencer sequencer_inst (
        .clk_i                     (clk_i),
        .rst_ni                    (rst_ni),
        .req_valid_i               (req_valid_i),
        .req_ready_o               (req_ready_o),
        .req_op_i                  (req_op_i),
        .req_addr_i                (req_addr_i),
        .req_wait_o                (req_wait_o),
        .wbuf_empty_i              (wbuf_empty_i),
        .mshr_empty_i              (mshr_empty_i),
        .rtab_empty_i              (rtab_empty_i),
        .wbuf_flush_all_o          (wbuf_flush_all_o),
        .dir_check_nline_o         (dir_check_nline_o),
        .dir_check_nline_set_o     (dir_check_nline_set_o),
        .dir_check_nline_tag_o     (dir_check_nline_tag_o),
        .dir_check_nline_hit_way_i (dir_check_nline_hit_way_i),
        .dir_check_entry_o         (dir_check_entry_o),
        .dir_check_entry_set_o     (dir_check_entry_set_o),
        .dir_check_entry_way_o     (dir_check_entry_way_o),
        .dir_check_entry_valid_i   (dir_check_entry_valid_i),
        .dir_check_entry_dirty_i   (dir_check_entry_dirty_i),
        .dir_check_entry_tag_i     (dir_check_entry_tag_i),
        .dir_inval_o               (dir_inval_o),
        .dir_inval_set_o           (dir_inval_set_o),
        .dir_inval_way_o           (dir_inval_way_o),
        .flush_empty_i             (flush_empty_i),
        .walk_start_o              (walk_start),
        .walk_step_way_o           (walk_step_way),
        .walk_step_set_o           (walk_step_set),
        .walk_set_i                (walk_set),
        .walk_way_i                (walk_way),
        .walk_set_last_i           (walk_set_last),
        .walk_way_last_i           (walk_way_last),
        .q_push_o                  (q_push),
        .q_nline_o                 (q_nline),
        .q_way_o                   (q_way),
        .q_space_i                 (q_space),
        .q_almost_full_i           (q_almost_full),
        .q_empty_i                 (q_empty)
    );

    cmo_walker #(
        .NUM_SETS (NUM_SETS)
    ) walker_inst (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .start_i    (walk_start),
        .step_way_i (walk_step_way),
        .step_set_i (walk_step_set),
        .set_o      (walk_set),
        .way_o      (walk_way),
        .set_last_o (walk_set_last),
        .way_last_o (walk_way_last)
    );

    cmo_flush_queue #(
        .FLUSH_DEPTH (FLUSH_DEPTH)
    ) flush_queue_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .push_i        (q_push),
        .nline_i       (q_nline),
        .way_i         (q_way),
        .space_o       (q_space),
        .almost_full_o (q_almost_full),
        .valid_o       (flush_alloc_o),
        .ready_i       (flush_alloc_ready_i),
        .nline_o       (flush_alloc_nline_o),
        .way_o         (flush_alloc_way_o),
        .empty_o       (q_empty)
    );

endmodule

//--- design/cmo_sequencer.sv
/* One operation at a time; the directory answers one cycle after each check.
   A new entry check is issued only while the queue keeps two or more free slots. */
`timescale 1ns/1ns

module cmo_sequencer
    import cache_geom_pkg::*;
    import cmo_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    input  cmo_op_e  req_op_i,
    input  addr_t    req_addr_i,
    output logic     req_wait_o,
    input  logic     wbuf_empty_i,
    input  logic     mshr_empty_i,
    input  logic     rtab_empty_i,
    output logic     wbuf_flush_all_o,
    output logic     dir_check_nline_o,
    output set_t     dir_check_nline_set_o,
    output tag_t     dir_check_nline_tag_o,
    input  way_vec_t dir_check_nline_hit_way_i,
    output logic     dir_check_entry_o,
    output set_t     dir_check_entry_set_o,
    output way_vec_t dir_check_entry_way_o,
    input  logic     dir_check_entry_valid_i,
    input  logic     dir_check_entry_dirty_i,
    input  tag_t     dir_check_entry_tag_i,
    output logic     dir_inval_o,
    output set_t     dir_inval_set_o,
    output way_vec_t dir_inval_way_o,
    input  logic     flush_empty_i,
    output logic     walk_start_o,
    output logic     walk_step_way_o,
    output logic     walk_step_set_o,
    input  set_t     walk_set_i,
    input  way_vec_t walk_way_i,
    input  logic     walk_set_last_i,
    input  logic     walk_way_last_i,
    output logic     q_push_o,
    output nline_t   q_nline_o,
    output way_vec_t q_way_o,
    input  logic     q_space_i,
    input  logic     q_almost_full_i,
    input  logic     q_empty_i
);

    cmo_state_e state_q, state_d;
    cmo_op_e    op_q;
    addr_t      addr_q;
    logic       pend_q, pend_d;
    set_t       pend_set_q, pend_set_d;
    way_vec_t   pend_way_q, pend_way_d;
    set_t       addr_set;
    logic       drained;
    logic       issue_ok;

    // First working state of a maintenance operation
    function automatic cmo_state_e first_state(input cmo_op_e op);
        cmo_state_e st;
        case (op)
            CMO_INVAL_NLINE: st = INVAL_CHECK;
            CMO_INVAL_ALL:   st = INVAL_SET;
            default:         st = FLUSH_WALK;
        endcase
        return st;
    endfunction

    assign addr_set = addr_q[OFFSET_WIDTH +: SET_WIDTH];
    assign drained  = mshr_empty_i && rtab_empty_i;
    assign issue_ok = q_space_i && !q_almost_full_i;

    assign req_ready_o = (state_q == IDLE);
    assign req_wait_o  = (state_q == FENCE_WAIT) || (state_q == DRAIN_WAIT);

    assign dir_check_nline_set_o = addr_set;
    assign dir_check_nline_tag_o = addr_q[OFFSET_WIDTH+SET_WIDTH +: TAG_WIDTH];
    assign dir_check_entry_set_o = walk_set_i;
    assign dir_check_entry_way_o = walk_way_i;

    // Queue entry is built from the answer and the check it belongs to
    assign q_nline_o = {dir_check_entry_tag_i, pend_set_q};
    assign q_way_o   = pend_way_q;

    always_comb begin
        state_d           = state_q;
        pend_d            = pend_q;
        pend_set_d        = pend_set_q;
        pend_way_d        = pend_way_q;
        wbuf_flush_all_o  = 1'b0;
        dir_check_nline_o = 1'b0;
        dir_check_entry_o = 1'b0;
        dir_inval_o       = 1'b0;
        dir_inval_set_o   = walk_set_i;
        dir_inval_way_o   = '1;
        walk_start_o      = 1'b0;
        walk_step_way_o   = 1'b0;
        walk_step_set_o   = 1'b0;
        q_push_o          = 1'b0;

        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    if (req_op_i == CMO_FENCE) begin
                        wbuf_flush_all_o = rtab_empty_i;
                        if (!(wbuf_empty_i && rtab_empty_i)) begin
                            state_d = FENCE_WAIT;
                        end
                    end else begin
                        walk_start_o = 1'b1;
                        state_d      = drained ? first_state(req_op_i) : DRAIN_WAIT;
                    end
                end
            end
            FENCE_WAIT: begin
                wbuf_flush_all_o = rtab_empty_i;
                if (wbuf_empty_i && rtab_empty_i) begin
                    state_d = IDLE;
                end
            end
            DRAIN_WAIT: begin
                if (drained) begin
                    state_d = first_state(op_q);
                end
            end
            INVAL_CHECK: begin
                dir_check_nline_o = 1'b1;
                state_d           = INVAL_SET;
            end
            INVAL_SET: begin
                if (op_q == CMO_INVAL_NLINE) begin
                    // Hit ways come back from the check of the previous cycle
                    dir_inval_o     = |dir_check_nline_hit_way_i;
                    dir_inval_set_o = addr_set;
                    dir_inval_way_o = dir_check_nline_hit_way_i;
                    state_d         = IDLE;
                end else begin
                    dir_inval_o     = 1'b1;
                    walk_step_set_o = 1'b1;
                    if (walk_set_last_i) begin
                        state_d = IDLE;
                    end
                end
            end
            FLUSH_WALK: begin
                if (pend_q) begin
                    q_push_o = dir_check_entry_valid_i && dir_check_entry_dirty_i;
                end
                pend_d = 1'b0;
                if (issue_ok) begin
                    dir_check_entry_o = 1'b1;
                    pend_d            = 1'b1;
                    pend_set_d        = walk_set_i;
                    pend_way_d        = walk_way_i;
                    walk_step_way_o   = 1'b1;
                    walk_step_set_o   = walk_way_last_i;
                    if (walk_set_last_i && walk_way_last_i) begin
                        state_d = FLUSH_LAST;
                    end
                end
            end
            FLUSH_LAST: begin
                if (pend_q) begin
                    q_push_o = dir_check_entry_valid_i && dir_check_entry_dirty_i;
                end
                pend_d = 1'b0;
                // Done once the queue and the flush controller hold nothing
                if (!pend_q && q_empty_i && flush_empty_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            pend_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            pend_q  <= pend_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            op_q   <= req_op_i;
            addr_q <= req_addr_i;
        end
        pend_set_q <= pend_set_d;
        pend_way_q <= pend_way_d;
    end

endmodule

//--- design/cmo_flush_queue.sv
/* Register FIFO of flush requests, FLUSH_DEPTH of at least 2. A push while full is dropped,
   so the writer must watch space_o and almost_full_o. */
`timescale 1ns/1ns

module cmo_flush_queue
    import cache_geom_pkg::*;
#(
    parameter int FLUSH_DEPTH = 3
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     push_i,
    input  nline_t   nline_i,
    input  way_vec_t way_i,
    output logic     space_o,
    output logic     almost_full_o,
    output logic     valid_o,
    input  logic     ready_i,
    output nline_t   nline_o,
    output way_vec_t way_o,
    output logic     empty_o
);

    localparam int PTR_WIDTH = $clog2(FLUSH_DEPTH);
    localparam int CNT_WIDTH = $clog2(FLUSH_DEPTH + 1);

    nline_t                 nline_mem [FLUSH_DEPTH];
    way_vec_t               way_mem   [FLUSH_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr_q;
    logic [PTR_WIDTH-1:0]   rd_ptr_q;
    logic [CNT_WIDTH-1:0]   count_q;
    logic                   do_push;
    logic                   do_pop;

    assign empty_o       = (count_q == '0);
    assign space_o       = (count_q != CNT_WIDTH'(FLUSH_DEPTH));
    assign almost_full_o = (count_q == CNT_WIDTH'(FLUSH_DEPTH - 1));
    assign valid_o       = !empty_o;
    assign nline_o       = nline_mem[rd_ptr_q];
    assign way_o         = way_mem[rd_ptr_q];

    assign do_push = push_i && space_o;
    assign do_pop  = valid_o && ready_i;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            nline_mem[wr_ptr_q] <= nline_i;
            way_mem[wr_ptr_q]   <= way_i;
        end
    end

    // Pointers wrap by compare since the depth need not be a power of two
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_WIDTH'(FLUSH_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_WIDTH'(FLUSH_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

//--- design/cmo_walker.sv
/* Directory walk position. NUM_SETS must not exceed 16, the range of set_t.
   Start has priority over the step inputs. */
`timescale 1ns/1ns

module cmo_walker
    import cache_geom_pkg::*;
#(
    parameter int NUM_SETS = 16
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     start_i,
    input  logic     step_way_i,
    input  logic     step_set_i,
    output set_t     set_o,
    output way_vec_t way_o,
    output logic     set_last_o,
    output logic     way_last_o
);

    set_t     set_q;
    way_vec_t way_q;

    assign set_last_o = (set_q == set_t'(NUM_SETS - 1));
    assign way_last_o = way_q[WAYS-1];
    assign set_o      = set_q;
    assign way_o      = way_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            set_q <= '0;
            way_q <= way_vec_t'(1);
        end else if (start_i) begin
            set_q <= '0;
            way_q <= way_vec_t'(1);
        end else begin
            // Way pointer rotates, so way 0 follows the last way
            if (step_way_i) begin
                way_q <= {way_q[WAYS-2:0], way_q[WAYS-1]};
            end
            if (step_set_i) begin
                set_q <= set_last_o ? '0 : set_q + set_t'(1);
            end
        end
    end

endmodule

//--- design/cmo_pkg.sv
/* Operation codes of the maintenance port and the sequencer states.
   Only four operations exist; flush by line is not supported. */
package cmo_pkg;

    // Request operation code on req_op_i
    typedef enum logic [1:0] {
        CMO_FENCE,
        CMO_INVAL_NLINE,
        CMO_INVAL_ALL,
        CMO_FLUSH_ALL
    } cmo_op_e;

    // Sequencer FSM states
    typedef enum {
        IDLE,
        FENCE_WAIT,
        DRAIN_WAIT,
        INVAL_CHECK,
        INVAL_SET,
        FLUSH_WALK,
        FLUSH_LAST
    } cmo_state_e;

endpackage

//--- design/cache_geom_pkg.sv
/* Fixed geometry of the data cache: 16-bit addresses, 16-byte lines, 16 sets, 4 ways.
   Widths here are not parameters, so changing them means rebuilding every user. */
package cache_geom_pkg;

    // Line offset, set index and tag widths
    localparam int OFFSET_WIDTH = 4;
    localparam int SET_WIDTH    = 4;
    localparam int TAG_WIDTH    = 8;
    localparam int WAYS         = 4;

    // Derived widths
    localparam int NLINE_WIDTH = TAG_WIDTH + SET_WIDTH;
    localparam int ADDR_WIDTH  = NLINE_WIDTH + OFFSET_WIDTH;

    // Byte address, tag on top and offset at the bottom
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    typedef logic [SET_WIDTH-1:0] set_t;

    typedef logic [TAG_WIDTH-1:0] tag_t;

    // Line address is the tag above the set index
    typedef logic [NLINE_WIDTH-1:0] nline_t;

    // One bit per way, one-hot for a single way or all ones for a whole set
    typedef logic [WAYS-1:0] way_vec_t;

endpackage
